// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fm_reg_tb
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/fm_map_pkg.sv ====
// FM register interface address map
// Global register addresses, channel and operator bases, and the
// kinds of pending slot update passed from decoder to slot store

package fm_map_pkg;

	// Global registers below the channel block
	typedef enum logic [7:0] {
		ADDR_KON   = 8'h08,
		ADDR_NOISE = 8'h0f,
		ADDR_CLKA1 = 8'h10,
		ADDR_CLKA2 = 8'h11,
		ADDR_CLKB  = 8'h12,
		ADDR_TIMER = 8'h14,
		ADDR_LFRQ  = 8'h18,
		ADDR_CTW   = 8'h1b
	} reg_addr_e;

	// Pending update queued for the slot scan
	typedef enum logic [2:0] {
		UPD_NONE,
		UPD_RL_FB_CON,
		UPD_KC,
		UPD_DT1_MUL,
		UPD_TL,
		UPD_KON
	} upd_kind_e;

	// Channel registers start here, operator registers follow
	localparam logic [7:0] CHAN_BASE = 8'h20;
	localparam logic [7:0] OPER_BASE = 8'h40;

endpackage

// ==== source/fm_mmr_decode.sv ====
// FM host register decoder
// Latches the register address, applies global registers at once and
// queues channel, operator and key-on writes as one pending slot update

module fm_mmr_decode (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic [7:0]                           d_in,
	input  logic                                 write,
	input  logic                                 a0,
	input  logic                                 upd_done,
	output logic                                 busy,
	output fm_map_pkg::upd_kind_e                upd_kind,
	output logic [fm_voice_pkg::CH_W-1:0]        upd_ch,
	output logic [fm_voice_pkg::OP_W-1:0]        upd_op,
	output logic [7:0]                           upd_data,
	output logic                                 ne,
	output logic [4:0]                           nfrq,
	output logic [7:0]                           lfo_freq,
	output logic [1:0]                           lfo_w,
	output logic                                 ct1,
	output logic                                 ct2,
	output logic [fm_voice_pkg::TIMER_A_W-1:0]   value_a,
	output logic [fm_voice_pkg::TIMER_B_W-1:0]   value_b,
	output logic                                 run_a,
	output logic                                 run_b,
	output logic                                 irq_en_a,
	output logic                                 irq_en_b,
	output logic                                 clr_flag_a,
	output logic                                 clr_flag_b
);

	logic [7:0]                    sel_addr;
	logic                          accept;
	logic                          is_chan;
	logic                          is_oper;
	fm_map_pkg::upd_kind_e         dec_kind;
	logic [fm_voice_pkg::CH_W-1:0] dec_ch;

	assign accept  = write && !busy;
	assign is_chan = (sel_addr >= fm_map_pkg::CHAN_BASE) && (sel_addr < fm_map_pkg::OPER_BASE);
	// Operator block runs up to 7Fh
	assign is_oper = (sel_addr >= fm_map_pkg::OPER_BASE) && !sel_addr[7];

	// Which slot update a data write to sel_addr would queue
	always_comb begin
		dec_kind = fm_map_pkg::UPD_NONE;
		dec_ch   = sel_addr[2:0];
		if (sel_addr == fm_map_pkg::ADDR_KON) begin
			dec_kind = fm_map_pkg::UPD_KON;
			// Key-on carries its channel in the data byte
			dec_ch   = d_in[2:0];
		end else if (is_chan) begin
			if (sel_addr[4:3] == 2'd0)
				dec_kind = fm_map_pkg::UPD_RL_FB_CON;
			else if (sel_addr[4:3] == 2'd1)
				dec_kind = fm_map_pkg::UPD_KC;
		end else if (is_oper) begin
			dec_kind = sel_addr[5] ? fm_map_pkg::UPD_TL : fm_map_pkg::UPD_DT1_MUL;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_addr   <= 8'h00;
			busy       <= 1'b0;
			upd_kind   <= fm_map_pkg::UPD_NONE;
			upd_ch     <= '0;
			upd_op     <= '0;
			upd_data   <= 8'h00;
			ne         <= 1'b0;
			nfrq       <= 5'd0;
			lfo_freq   <= 8'h00;
			lfo_w      <= 2'd0;
			ct1        <= 1'b0;
			ct2        <= 1'b0;
			value_a    <= '0;
			value_b    <= '0;
			run_a      <= 1'b0;
			run_b      <= 1'b0;
			irq_en_a   <= 1'b0;
			irq_en_b   <= 1'b0;
			clr_flag_a <= 1'b0;
			clr_flag_b <= 1'b0;
		end else begin
			// Flag clears are single-cycle strobes
			clr_flag_a <= 1'b0;
			clr_flag_b <= 1'b0;

			if (accept) begin
				busy <= 1'b1;
				if (!a0) begin
					sel_addr <= d_in;
				end else if (dec_kind != fm_map_pkg::UPD_NONE) begin
					upd_kind <= dec_kind;
					upd_ch   <= dec_ch;
					upd_op   <= (dec_kind == fm_map_pkg::UPD_KON) ? '0 : sel_addr[4:3];
					upd_data <= d_in;
				end else begin
					case (sel_addr)
						fm_map_pkg::ADDR_NOISE: begin
							ne   <= d_in[7];
							nfrq <= d_in[4:0];
						end
						fm_map_pkg::ADDR_CLKA1: value_a[9:2] <= d_in;
						fm_map_pkg::ADDR_CLKA2: value_a[1:0] <= d_in[1:0];
						fm_map_pkg::ADDR_CLKB:  value_b      <= d_in;
						fm_map_pkg::ADDR_TIMER: begin
							run_a      <= d_in[0];
							run_b      <= d_in[1];
							irq_en_a   <= d_in[2];
							irq_en_b   <= d_in[3];
							clr_flag_a <= d_in[4];
							clr_flag_b <= d_in[5];
						end
						fm_map_pkg::ADDR_LFRQ: lfo_freq <= d_in;
						fm_map_pkg::ADDR_CTW: begin
							ct2   <= d_in[7];
							ct1   <= d_in[6];
							lfo_w <= d_in[1:0];
						end
						// Unmapped addresses only pulse busy
						default: ;
					endcase
				end
			end else if (upd_done) begin
				upd_kind <= fm_map_pkg::UPD_NONE;
				busy     <= 1'b0;
			end else begin
				// Stay busy while a slot update waits for the scan
				busy <= (upd_kind != fm_map_pkg::UPD_NONE);
			end
		end
	end

endmodule

// ==== source/fm_reg_top.sv ====
// FM host register interface top level
// Decoder, slot parameter store and timers joined together

module fm_reg_top (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [7:0]                         d_in,
	input  logic                               write,
	input  logic                               a0,
	output logic                               busy,
	output logic                               ne,
	output logic [4:0]                         nfrq,
	output logic [7:0]                         lfo_freq,
	output logic [1:0]                         lfo_w,
	output logic                               ct1,
	output logic                               ct2,
	output logic [fm_voice_pkg::SLOT_W-1:0]    slot,
	output logic [fm_voice_pkg::RL_W-1:0]      rl,
	output logic [fm_voice_pkg::FB_W-1:0]      fb,
	output logic [fm_voice_pkg::CON_W-1:0]     con,
	output logic [fm_voice_pkg::KC_W-1:0]      kc,
	output logic [fm_voice_pkg::DT1_W-1:0]     dt1,
	output logic [fm_voice_pkg::MUL_W-1:0]     mul,
	output logic [fm_voice_pkg::TL_W-1:0]      tl,
	output logic                               kon,
	output logic                               flag_a,
	output logic                               flag_b,
	output logic                               irq
);

	// Pending slot update
	fm_map_pkg::upd_kind_e         upd_kind;
	logic [fm_voice_pkg::CH_W-1:0] upd_ch;
	logic [fm_voice_pkg::OP_W-1:0] upd_op;
	logic [7:0]                    upd_data;
	logic                          upd_done;
	logic                          scan_wrap;

	// Timer control
	logic [fm_voice_pkg::TIMER_A_W-1:0] value_a;
	logic [fm_voice_pkg::TIMER_B_W-1:0] value_b;
	logic run_a, run_b;
	logic irq_en_a, irq_en_b;
	logic clr_flag_a, clr_flag_b;

	fm_mmr_decode u_decode (
		.clk        (clk),
		.rst        (rst),
		.d_in       (d_in),
		.write      (write),
		.a0         (a0),
		.upd_done   (upd_done),
		.busy       (busy),
		.upd_kind   (upd_kind),
		.upd_ch     (upd_ch),
		.upd_op     (upd_op),
		.upd_data   (upd_data),
		.ne         (ne),
		.nfrq       (nfrq),
		.lfo_freq   (lfo_freq),
		.lfo_w      (lfo_w),
		.ct1        (ct1),
		.ct2        (ct2),
		.value_a    (value_a),
		.value_b    (value_b),
		.run_a      (run_a),
		.run_b      (run_b),
		.irq_en_a   (irq_en_a),
		.irq_en_b   (irq_en_b),
		.clr_flag_a (clr_flag_a),
		.clr_flag_b (clr_flag_b)
	);

	fm_slot_store u_store (
		.clk       (clk),
		.rst       (rst),
		.upd_kind  (upd_kind),
		.upd_ch    (upd_ch),
		.upd_op    (upd_op),
		.upd_data  (upd_data),
		.upd_done  (upd_done),
		.scan_wrap (scan_wrap),
		.slot      (slot),
		.rl        (rl),
		.fb        (fb),
		.con       (con),
		.kc        (kc),
		.dt1       (dt1),
		.mul       (mul),
		.tl        (tl),
		.kon       (kon)
	);

	fm_timers u_timers (
		.clk        (clk),
		.rst        (rst),
		.scan_wrap  (scan_wrap),
		.value_a    (value_a),
		.value_b    (value_b),
		.run_a      (run_a),
		.run_b      (run_b),
		.irq_en_a   (irq_en_a),
		.irq_en_b   (irq_en_b),
		.clr_flag_a (clr_flag_a),
		.clr_flag_b (clr_flag_b),
		.flag_a     (flag_a),
		.flag_b     (flag_b),
		.irq        (irq)
	);

endmodule

// ==== source/fm_slot_store.sv ====
// FM slot parameter store
// Rotating scan over 32 slots applies the pending update when it reaches
// the target and streams one slot's parameters per cycle

module fm_slot_store (
	input  logic                               clk,
	input  logic                               rst,
	input  fm_map_pkg::upd_kind_e              upd_kind,
	input  logic [fm_voice_pkg::CH_W-1:0]      upd_ch,
	input  logic [fm_voice_pkg::OP_W-1:0]      upd_op,
	input  logic [7:0]                         upd_data,
	output logic                               upd_done,
	output logic                               scan_wrap,
	output logic [fm_voice_pkg::SLOT_W-1:0]    slot,
	output logic [fm_voice_pkg::RL_W-1:0]      rl,
	output logic [fm_voice_pkg::FB_W-1:0]      fb,
	output logic [fm_voice_pkg::CON_W-1:0]     con,
	output logic [fm_voice_pkg::KC_W-1:0]      kc,
	output logic [fm_voice_pkg::DT1_W-1:0]     dt1,
	output logic [fm_voice_pkg::MUL_W-1:0]     mul,
	output logic [fm_voice_pkg::TL_W-1:0]      tl,
	output logic                               kon
);

	// Per-channel fields
	logic [fm_voice_pkg::RL_W-1:0]  rl_mem  [1 << fm_voice_pkg::CH_W];
	logic [fm_voice_pkg::FB_W-1:0]  fb_mem  [1 << fm_voice_pkg::CH_W];
	logic [fm_voice_pkg::CON_W-1:0] con_mem [1 << fm_voice_pkg::CH_W];
	logic [fm_voice_pkg::KC_W-1:0]  kc_mem  [1 << fm_voice_pkg::CH_W];

	// Per-slot fields, indexed {op, ch}
	logic [fm_voice_pkg::DT1_W-1:0] dt1_mem [fm_voice_pkg::SLOT_COUNT];
	logic [fm_voice_pkg::MUL_W-1:0] mul_mem [fm_voice_pkg::SLOT_COUNT];
	logic [fm_voice_pkg::TL_W-1:0]  tl_mem  [fm_voice_pkg::SLOT_COUNT];
	logic                           kon_mem [fm_voice_pkg::SLOT_COUNT];

	logic [fm_voice_pkg::SLOT_W-1:0] scan_idx;
	logic [fm_voice_pkg::OP_W-1:0]   scan_op;
	logic [fm_voice_pkg::CH_W-1:0]   scan_ch;
	logic                            ch_hit;
	logic                            hit;

	assign scan_op = scan_idx[fm_voice_pkg::SLOT_W-1 -: fm_voice_pkg::OP_W];
	assign scan_ch = scan_idx[fm_voice_pkg::CH_W-1:0];
	assign ch_hit  = (scan_ch == upd_ch);

	always_comb begin
		case (upd_kind)
			fm_map_pkg::UPD_RL_FB_CON,
			fm_map_pkg::UPD_KC,
			fm_map_pkg::UPD_KON:     hit = ch_hit;
			fm_map_pkg::UPD_DT1_MUL,
			fm_map_pkg::UPD_TL:      hit = ch_hit && (scan_op == upd_op);
			default:                 hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			scan_idx  <= '0;
			scan_wrap <= 1'b0;
			upd_done  <= 1'b0;
		end else begin
			scan_idx  <= scan_idx + 1'b1;
			scan_wrap <= (scan_idx == fm_voice_pkg::SLOT_W'(fm_voice_pkg::SLOT_COUNT - 1));
			upd_done  <= hit;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < (1 << fm_voice_pkg::CH_W); i++) begin
				rl_mem[i]  <= '0;
				fb_mem[i]  <= '0;
				con_mem[i] <= '0;
				kc_mem[i]  <= '0;
			end
			for (int i = 0; i < fm_voice_pkg::SLOT_COUNT; i++) begin
				dt1_mem[i] <= '0;
				mul_mem[i] <= '0;
				tl_mem[i]  <= '0;
				kon_mem[i] <= 1'b0;
			end
		end else if (hit) begin
			case (upd_kind)
				fm_map_pkg::UPD_RL_FB_CON: begin
					rl_mem[upd_ch]  <= upd_data[7:6];
					fb_mem[upd_ch]  <= upd_data[5:3];
					con_mem[upd_ch] <= upd_data[2:0];
				end
				fm_map_pkg::UPD_KC: kc_mem[upd_ch] <= upd_data[6:0];
				fm_map_pkg::UPD_DT1_MUL: begin
					dt1_mem[{upd_op, upd_ch}] <= upd_data[6:4];
					mul_mem[{upd_op, upd_ch}] <= upd_data[3:0];
				end
				fm_map_pkg::UPD_TL: tl_mem[{upd_op, upd_ch}] <= upd_data[6:0];
				fm_map_pkg::UPD_KON: begin
					// Mask bit 3 is operator 0, bit 6 operator 3
					for (int op = 0; op < (1 << fm_voice_pkg::OP_W); op++)
						kon_mem[{fm_voice_pkg::OP_W'(op), upd_ch}] <= upd_data[3 + op];
				end
				default: ;
			endcase
		end
	end

	// Slot index and its fields leave together
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
			rl   <= '0;
			fb   <= '0;
			con  <= '0;
			kc   <= '0;
			dt1  <= '0;
			mul  <= '0;
			tl   <= '0;
			kon  <= 1'b0;
		end else begin
			slot <= scan_idx;
			rl   <= rl_mem[scan_ch];
			fb   <= fb_mem[scan_ch];
			con  <= con_mem[scan_ch];
			kc   <= kc_mem[scan_ch];
			dt1  <= dt1_mem[scan_idx];
			mul  <= mul_mem[scan_idx];
			tl   <= tl_mem[scan_idx];
			kon  <= kon_mem[scan_idx];
		end
	end

endmodule

// ==== source/fm_timers.sv ====
// FM timers A and B
// Up-counters clocked by scan wraps, B through a divide-by-16 prescaler;
// overflow sets a sticky flag, reloads the count and may raise irq

module fm_timers (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                scan_wrap,
	input  logic [fm_voice_pkg::TIMER_A_W-1:0]  value_a,
	input  logic [fm_voice_pkg::TIMER_B_W-1:0]  value_b,
	input  logic                                run_a,
	input  logic                                run_b,
	input  logic                                irq_en_a,
	input  logic                                irq_en_b,
	input  logic                                clr_flag_a,
	input  logic                                clr_flag_b,
	output logic                                flag_a,
	output logic                                flag_b,
	output logic                                irq
);

	logic [$clog2(fm_voice_pkg::TIMER_B_DIV)-1:0] pre_cnt;
	logic [fm_voice_pkg::TIMER_A_W-1:0]           cnt_a;
	logic [fm_voice_pkg::TIMER_B_W-1:0]           cnt_b;
	logic run_a_q, run_b_q;
	logic wrap_b;
	logic tick_a, tick_b;
	logic ovf_a, ovf_b;

	assign wrap_b = scan_wrap && (pre_cnt == fm_voice_pkg::TIMER_B_DIV - 1);
	// Counting starts the cycle after the run edge has loaded the value
	assign tick_a = run_a && run_a_q && scan_wrap;
	assign tick_b = run_b && run_b_q && wrap_b;
	assign ovf_a  = tick_a && (&cnt_a);
	assign ovf_b  = tick_b && (&cnt_b);

	assign irq = (flag_a && irq_en_a) || (flag_b && irq_en_b);

	always_ff @(posedge clk) begin
		if (rst) begin
			pre_cnt <= '0;
			run_a_q <= 1'b0;
			run_b_q <= 1'b0;
			cnt_a   <= '0;
			cnt_b   <= '0;
			flag_a  <= 1'b0;
			flag_b  <= 1'b0;
		end else begin
			run_a_q <= run_a;
			run_b_q <= run_b;

			if (wrap_b)
				pre_cnt <= '0;
			else if (scan_wrap)
				pre_cnt <= pre_cnt + 1'b1;

			if ((run_a && !run_a_q) || ovf_a)
				cnt_a <= value_a;
			else if (tick_a)
				cnt_a <= cnt_a + 1'b1;

			if ((run_b && !run_b_q) || ovf_b)
				cnt_b <= value_b;
			else if (tick_b)
				cnt_b <= cnt_b + 1'b1;

			// An overflow wins over a clear in the same cycle
			if (ovf_a)
				flag_a <= 1'b1;
			else if (clr_flag_a)
				flag_a <= 1'b0;

			if (ovf_b)
				flag_b <= 1'b1;
			else if (clr_flag_b)
				flag_b <= 1'b0;
		end
	end

endmodule

// ==== source/fm_voice_pkg.sv ====
// FM voice store geometry
// Slot count, index widths, per-field parameter widths and timer sizes

package fm_voice_pkg;

	// Eight channels times four operators
	localparam int SLOT_COUNT = 32;
	localparam int SLOT_W     = 5;
	localparam int CH_W       = 3;
	localparam int OP_W       = 2;

	// Channel fields
	localparam int RL_W  = 2;
	localparam int FB_W  = 3;
	localparam int CON_W = 3;
	localparam int KC_W  = 7;

	// Operator fields
	localparam int DT1_W = 3;
	localparam int MUL_W = 4;
	localparam int TL_W  = 7;

	// Timers, B ticks once per 16 scan wraps
	localparam int TIMER_A_W   = 10;
	localparam int TIMER_B_W   = 8;
	localparam int TIMER_B_DIV = 16;

endpackage

// ==== verification/fm_reg_tb.sv ====
// FM register interface testbench
// Random host writes checked against a register model of the slot store,
// plus busy protocol and timer A/B runs

module fm_reg_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BUSY_LIMIT = 40;

	logic                               clk;
	logic                               rst;
	logic [7:0]                         d_in;
	logic                               write;
	logic                               a0;
	logic                               busy;
	logic                               ne;
	logic [4:0]                         nfrq;
	logic [7:0]                         lfo_freq;
	logic [1:0]                         lfo_w;
	logic                               ct1;
	logic                               ct2;
	logic [fm_voice_pkg::SLOT_W-1:0]    slot;
	logic [fm_voice_pkg::RL_W-1:0]      rl;
	logic [fm_voice_pkg::FB_W-1:0]      fb;
	logic [fm_voice_pkg::CON_W-1:0]     con;
	logic [fm_voice_pkg::KC_W-1:0]      kc;
	logic [fm_voice_pkg::DT1_W-1:0]     dt1;
	logic [fm_voice_pkg::MUL_W-1:0]     mul;
	logic [fm_voice_pkg::TL_W-1:0]      tl;
	logic                               kon;
	logic                               flag_a;
	logic                               flag_b;
	logic                               irq;

	// Register model
	logic [fm_voice_pkg::RL_W-1:0]  m_rl  [8];
	logic [fm_voice_pkg::FB_W-1:0]  m_fb  [8];
	logic [fm_voice_pkg::CON_W-1:0] m_con [8];
	logic [fm_voice_pkg::KC_W-1:0]  m_kc  [8];
	logic [fm_voice_pkg::DT1_W-1:0] m_dt1 [32];
	logic [fm_voice_pkg::MUL_W-1:0] m_mul [32];
	logic [fm_voice_pkg::TL_W-1:0]  m_tl  [32];
	logic                           m_kon [32];
	logic                           m_ne;
	logic [4:0]                     m_nfrq;
	logic [7:0]                     m_lfo_freq;
	logic [1:0]                     m_lfo_w;
	logic                           m_ct1;
	logic                           m_ct2;

	logic [31:0] lcg_state;
	int          checks;
	int          errors;
	int          tests;

	fm_reg_top dut (
		.clk      (clk),
		.rst      (rst),
		.d_in     (d_in),
		.write    (write),
		.a0       (a0),
		.busy     (busy),
		.ne       (ne),
		.nfrq     (nfrq),
		.lfo_freq (lfo_freq),
		.lfo_w    (lfo_w),
		.ct1      (ct1),
		.ct2      (ct2),
		.slot     (slot),
		.rl       (rl),
		.fb       (fb),
		.con      (con),
		.kc       (kc),
		.dt1      (dt1),
		.mul      (mul),
		.tl       (tl),
		.kon      (kon),
		.flag_a   (flag_a),
		.flag_b   (flag_b),
		.irq      (irq)
	);

	always #10 clk = ~clk;

	// Upper 24 bits of the LCG state, low bits repeat too soon
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("t=%0t %s", $time, msg);
	endtask

	task automatic end_test(input string name, input int mark);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - mark);
	endtask

	// Register rules applied to the model
	task automatic model_write(input logic [7:0] addr, input logic [7:0] data);
		int ch;
		int sl;
		ch = int'(addr[2:0]);
		sl = int'(addr[4:0]);
		if (addr == 8'h08) begin
			for (int op = 0; op < 4; op++)
				m_kon[op * 8 + int'(data[2:0])] = data[3 + op];
		end else if (addr == 8'h0f) begin
			m_ne   = data[7];
			m_nfrq = data[4:0];
		end else if (addr == 8'h18) begin
			m_lfo_freq = data;
		end else if (addr == 8'h1b) begin
			m_ct2   = data[7];
			m_ct1   = data[6];
			m_lfo_w = data[1:0];
		end else if (addr >= 8'h20 && addr <= 8'h27) begin
			m_rl[ch]  = data[7:6];
			m_fb[ch]  = data[5:3];
			m_con[ch] = data[2:0];
		end else if (addr >= 8'h28 && addr <= 8'h2f) begin
			m_kc[ch] = data[6:0];
		end else if (addr >= 8'h40 && addr <= 8'h5f) begin
			m_dt1[sl] = data[6:4];
			m_mul[sl] = data[3:0];
		end else if (addr >= 8'h60 && addr <= 8'h7f) begin
			m_tl[sl] = data[6:0];
		end
	endtask

	task automatic wait_idle(input string what);
		int n;
		n = 0;
		while (busy && n < BUSY_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (busy)
			note_failure($sformatf("timeout: busy stayed high for %0d cycles %s",
				BUSY_LIMIT, what));
	endtask

	// One-cycle host write, returns in the cycle after it was taken
	task automatic send(input logic sel, input logic [7:0] data);
		wait_idle("before a host write");
		a0    = sel;
		d_in  = data;
		write = 1'b1;
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic write_while_busy(input logic sel, input logic [7:0] data);
		if (!busy)
			note_failure("busy was low when a write during busy was attempted");
		a0    = sel;
		d_in  = data;
		write = 1'b1;
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic reg_write(input logic [7:0] addr, input logic [7:0] data);
		send(1'b0, addr);
		send(1'b1, data);
		wait_idle("after a register write");
		model_write(addr, data);
	endtask

	task automatic check_globals();
		compare_value("ne", ne, m_ne);
		compare_value("nfrq", nfrq, m_nfrq);
		compare_value("lfo_freq", lfo_freq, m_lfo_freq);
		compare_value("lfo_w", lfo_w, m_lfo_w);
		compare_value("ct1", ct1, m_ct1);
		compare_value("ct2", ct2, m_ct2);
	endtask

	// Two full scans, every slot seen twice
	task automatic check_slots();
		int s;
		int c;
		int prev;
		prev = 0;
		for (int i = 0; i < 64; i++) begin
			@(negedge clk);
			s = int'(slot);
			c = s % 8;
			if (i > 0)
				compare_value("slot", slot, (prev + 1) % 32);
			prev = s;
			compare_value("rl", rl, m_rl[c]);
			compare_value("fb", fb, m_fb[c]);
			compare_value("con", con, m_con[c]);
			compare_value("kc", kc, m_kc[c]);
			compare_value("dt1", dt1, m_dt1[s]);
			compare_value("mul", mul, m_mul[s]);
			compare_value("tl", tl, m_tl[s]);
			compare_value("kon", kon, m_kon[s]);
		end
	endtask

	task automatic wait_timer_flag(input bit timer_b, input int limit);
		int n;
		n = 0;
		while (!(timer_b ? flag_b : flag_a) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!(timer_b ? flag_b : flag_a))
			note_failure($sformatf("timeout: flag_%s did not rise within %0d cycles",
				timer_b ? "b" : "a", limit));
	endtask

	initial begin
		logic [31:0] rnd;
		logic [7:0]  addr;
		logic [7:0]  data;
		int          mark;
		clk       = 1'b0;
		rst       = 1'b1;
		d_in      = 8'h00;
		write     = 1'b0;
		a0        = 1'b0;
		lcg_state = 32'hcea;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		for (int i = 0; i < 8; i++) begin
			m_rl[i]  = '0;
			m_fb[i]  = '0;
			m_con[i] = '0;
			m_kc[i]  = '0;
		end
		for (int i = 0; i < 32; i++) begin
			m_dt1[i] = '0;
			m_mul[i] = '0;
			m_tl[i]  = '0;
			m_kon[i] = 1'b0;
		end
		m_ne       = 1'b0;
		m_nfrq     = '0;
		m_lfo_freq = '0;
		m_lfo_w    = '0;
		m_ct1      = 1'b0;
		m_ct2      = 1'b0;
		repeat (4) @(negedge clk);
		rst = 1'b0;

		mark = errors;
		compare_value("busy", busy, 0);
		compare_value("irq", irq, 0);
		for (int i = 0; i < 12; i++) begin
			rnd = next_rand();
			case (i % 3)
				0:       addr = 8'h0f;
				1:       addr = 8'h18;
				default: addr = 8'h1b;
			endcase
			data = rnd[7:0];
			send(1'b0, addr);
			compare_value("busy", busy, 1);
			@(negedge clk);
			compare_value("busy", busy, 0);
			send(1'b1, data);
			model_write(addr, data);
			compare_value("busy", busy, 1);
			check_globals();
			@(negedge clk);
			compare_value("busy", busy, 0);
		end
		end_test("global registers", mark);

		// Includes the unmapped 30h-3Fh range
		mark = errors;
		for (int i = 0; i < 80; i++) begin
			rnd  = next_rand();
			addr = 8'h20 + (rnd[15:8] % 8'h60);
			reg_write(addr, rnd[7:0]);
		end
		check_slots();
		end_test("channel and operator registers", mark);

		mark = errors;
		for (int i = 0; i < 16; i++) begin
			rnd = next_rand();
			reg_write(8'h08, rnd[23:16]);
		end
		check_slots();
		end_test("key-on", mark);

		mark = errors;
		rnd  = next_rand();
		addr = 8'h60 | {3'b000, rnd[4:0]};
		send(1'b0, addr);
		write_while_busy(1'b0, 8'h40 | {3'b000, rnd[12:8]});
		send(1'b1, rnd[23:16]);
		wait_idle("after a slot write");
		model_write(addr, rnd[23:16]);
		rnd  = next_rand();
		addr = 8'h28 | {5'b00000, rnd[18:16]};
		data = rnd[15:8];
		send(1'b0, addr);
		send(1'b1, data);
		write_while_busy(1'b1, ~data);
		wait_idle("after a slot write");
		model_write(addr, data);
		rnd  = next_rand();
		data = rnd[15:8];
		send(1'b0, 8'h18);
		send(1'b1, data);
		write_while_busy(1'b1, ~data);
		wait_idle("after a global write");
		model_write(8'h18, data);
		check_globals();
		check_slots();
		end_test("busy protocol", mark);

		// Timer A value 1020 overflows on the fourth tick
		mark = errors;
		compare_value("flag_a", flag_a, 0);
		reg_write(8'h10, 8'hff);
		reg_write(8'h11, 8'h00);
		reg_write(8'h14, 8'h05);
		wait_timer_flag(1'b0, 6 * 32);
		compare_value("flag_a", flag_a, 1);
		compare_value("irq", irq, 1);
		reg_write(8'h14, 8'h01);
		compare_value("flag_a", flag_a, 1);
		compare_value("irq", irq, 0);
		reg_write(8'h14, 8'h10);
		compare_value("flag_a", flag_a, 0);
		compare_value("irq", irq, 0);
		end_test("timer A", mark);

		mark = errors;
		compare_value("flag_b", flag_b, 0);
		reg_write(8'h12, 8'hfe);
		reg_write(8'h14, 8'h02);
		wait_timer_flag(1'b1, 3 * 16 * 32);
		compare_value("flag_b", flag_b, 1);
		compare_value("irq", irq, 0);
		reg_write(8'h14, 8'h20);
		compare_value("flag_b", flag_b, 0);
		end_test("timer B", mark);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/fm_map_pkg.sv
source/fm_voice_pkg.sv
source/fm_mmr_decode.sv
source/fm_slot_store.sv
source/fm_timers.sv
source/fm_reg_top.sv
verification/fm_reg_tb.sv
